//--- rtl/soc_dma_cfg.svh
// Build-time widths, sizes and register map of the SRAM/DMA streaming subsystem
`ifndef SOC_DMA_CFG_SVH
`define SOC_DMA_CFG_SVH

// Data path and address widths
`define SOC_WORD_W        64
`define SOC_ADDR_W        32

// Shared SRAM size in words
`define SOC_SRAM_DEPTH    1024

// MMIO window, 4 KB at 0x4000_0000
`define SOC_MMIO_BASE     32'h4000_0000
`define SOC_MMIO_MASK     32'hFFFF_F000

// DMA register offsets inside the window
`define SOC_REG_CONTROL   32'h0000_0000
`define SOC_REG_SRC_RX    32'h0000_0008
`define SOC_REG_DST_TX    32'h0000_0010
`define SOC_REG_LEN_RX    32'h0000_0018
`define SOC_REG_LEN_TX    32'h0000_001C
`define SOC_REG_STATUS    32'h0000_0020

// Packet geometry: 3 words carry one 192-bit flat packet, 185 bits used
`define SOC_BEATS_PER_PKT 3
`define SOC_PKT_FLAT_W    192
`define SOC_CGRA_PKT_W    185

`endif

//--- rtl/soc_mem_pkg.sv
// Memory-side types shared by the SRAM, CSR block, DMA engines and loopback
`include "soc_dma_cfg.svh"

package soc_mem_pkg;

  // --------------------------------------------------
  // Addressing and data
  // --------------------------------------------------

  // Byte address as seen on the host port and engine ports
  typedef logic [`SOC_ADDR_W-1:0] mem_addr_t;

  // One SRAM word
  typedef logic [`SOC_WORD_W-1:0] mem_word_t;

  // --------------------------------------------------
  // Streaming
  // --------------------------------------------------

  // Number of packets in one DMA job
  typedef logic [31:0] pkt_count_t;

  // Flat packet, word j of the SRAM image sits at bits 64j and up
  typedef logic [`SOC_PKT_FLAT_W-1:0] pkt_flat_t;

endpackage

//--- rtl/cgra_pkt_pkg.sv
// Structured CGRA packet layout with conversion to and from the flat bit vector
`include "soc_dma_cfg.svh"

package cgra_pkt_pkg;

  // --------------------------------------------------
  // Payload pieces
  // --------------------------------------------------

  // Data word with its flags, 35 bits
  typedef struct packed {
    logic [31:0] payload;
    logic        predicate;
    logic        bypass;
    logic        delay;
  } cgra_data_t;

  // Control word for one tile, 107 bits
  typedef struct packed {
    logic [6:0]  operation;
    logic [11:0] fu_in;                // 4 inputs x 3 bits
    logic [23:0] routing_xbar_outport; // 8 ports x 3 bits
    logic [15:0] fu_xbar_outport;      // 8 ports x 2 bits
    logic [2:0]  vector_factor_power;
    logic        is_last_ctrl;
    logic [7:0]  write_reg_from;
    logic [15:0] write_reg_idx;
    logic [3:0]  read_reg_from;
    logic [15:0] read_reg_idx;
  } cgra_ctrl_t;

  // Command with data and control, 158 bits
  typedef struct packed {
    logic [4:0] cmd;
    cgra_data_t data;
    logic [6:0] data_addr;
    cgra_ctrl_t ctrl;
    logic [3:0] ctrl_addr;
  } cgra_payload_t;

  // --------------------------------------------------
  // Full packet
  // --------------------------------------------------

  // 27-bit routing header in front of the payload, 185 bits overall
  typedef struct packed {
    logic [4:0]    src;
    logic [4:0]    dst;
    logic [1:0]    src_cgra_id;
    logic [1:0]    dst_cgra_id;
    logic          src_cgra_x;
    logic          src_cgra_y;
    logic          dst_cgra_x;
    logic          dst_cgra_y;
    logic [7:0]    opaque;
    logic          vc_id;
    cgra_payload_t payload;
  } cgra_pkt_t;

  // Packed field order puts the header at the MSB end and ctrl_addr at bit 0
  function automatic logic [`SOC_CGRA_PKT_W-1:0] pack_pkt(input cgra_pkt_t p);
    return p;
  endfunction

  // Inverse of pack_pkt, identity on the 185 bits
  function automatic cgra_pkt_t unpack_pkt(input logic [`SOC_CGRA_PKT_W-1:0] v);
    return cgra_pkt_t'(v);
  endfunction

endpackage

//--- rtl/dma_csr.sv
// Host-port MMIO decode with the DMA control and status registers
`timescale 1ns/10ps
`include "soc_dma_cfg.svh"

module dma_csr (
  input  logic                    clk,
  input  logic                    rstn,
  // Host port
  input  soc_mem_pkg::mem_addr_t  host_addr_i,
  input  soc_mem_pkg::mem_word_t  host_wdata_i,
  input  logic                    host_we_i,
  output soc_mem_pkg::mem_word_t  host_rdata_o,
  // SRAM side of the host port
  output logic                    ram_we_o,
  input  soc_mem_pkg::mem_word_t  ram_rdata_i,
  // RX engine control
  output logic                    start_rx_o,
  output soc_mem_pkg::mem_addr_t  src_rx_o,
  output soc_mem_pkg::pkt_count_t len_rx_o,
  input  logic                    busy_rx_i,
  input  logic                    done_rx_i,
  // TX engine control
  output logic                    start_tx_o,
  output soc_mem_pkg::mem_addr_t  dst_tx_o,
  output soc_mem_pkg::pkt_count_t len_tx_o,
  input  logic                    busy_tx_i,
  input  logic                    done_tx_i
);
  import soc_mem_pkg::*;

  logic      is_mmio;
  mem_addr_t reg_off;
  mem_word_t reg_rdata;
  logic      done_rx_q;
  logic      done_tx_q;

  // --------------------------------------------------
  // Window decode
  // --------------------------------------------------
  assign is_mmio  = (host_addr_i & `SOC_MMIO_MASK) == (`SOC_MMIO_BASE & `SOC_MMIO_MASK);
  assign reg_off  = host_addr_i & ~`SOC_MMIO_MASK;
  // Register writes never reach the SRAM
  assign ram_we_o = host_we_i && !is_mmio;

  // --------------------------------------------------
  // Register write side
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      start_rx_o <= 1'b0;
      start_tx_o <= 1'b0;
      done_rx_q  <= 1'b0;
      done_tx_q  <= 1'b0;
      src_rx_o   <= '0;
      dst_tx_o   <= '0;
      len_rx_o   <= '0;
      len_tx_o   <= '0;
    end else begin
      // One-shot start, dropped once the engine reports busy
      if (start_rx_o && busy_rx_i) start_rx_o <= 1'b0;
      if (start_tx_o && busy_tx_i) start_tx_o <= 1'b0;
      // Sticky completion flags
      if (done_rx_i) done_rx_q <= 1'b1;
      if (done_tx_i) done_tx_q <= 1'b1;
      if (host_we_i && is_mmio) begin
        case (reg_off)
          `SOC_REG_CONTROL: begin
            // Writing a start bit also clears the matching done flag
            if (host_wdata_i[0]) begin
              start_rx_o <= 1'b1;
              done_rx_q  <= 1'b0;
            end
            if (host_wdata_i[1]) begin
              start_tx_o <= 1'b1;
              done_tx_q  <= 1'b0;
            end
          end
          `SOC_REG_SRC_RX: src_rx_o <= host_wdata_i[`SOC_ADDR_W-1:0];
          `SOC_REG_DST_TX: dst_tx_o <= host_wdata_i[`SOC_ADDR_W-1:0];
          `SOC_REG_LEN_RX: len_rx_o <= host_wdata_i[31:0];
          `SOC_REG_LEN_TX: len_tx_o <= host_wdata_i[31:0];
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    case (reg_off)
      `SOC_REG_CONTROL: reg_rdata = mem_word_t'({start_tx_o, start_rx_o});
      `SOC_REG_SRC_RX:  reg_rdata = mem_word_t'(src_rx_o);
      `SOC_REG_DST_TX:  reg_rdata = mem_word_t'(dst_tx_o);
      `SOC_REG_LEN_RX:  reg_rdata = mem_word_t'(len_rx_o);
      `SOC_REG_LEN_TX:  reg_rdata = mem_word_t'(len_tx_o);
      // STATUS: done_tx, busy_tx, done_rx, busy_rx from bit 3 down
      `SOC_REG_STATUS:  reg_rdata = mem_word_t'({done_tx_q, busy_tx_i, done_rx_q, busy_rx_i});
      default:          reg_rdata = '0;
    endcase
  end

  assign host_rdata_o = is_mmio ? reg_rdata : ram_rdata_i;

endmodule

//--- rtl/shared_sram.sv
// Word SRAM shared by the host port and the two DMA engines, host first then TX then RX
`timescale 1ns/10ps
`include "soc_dma_cfg.svh"

module shared_sram (
  input  logic                   clk,
  input  logic                   rstn,
  // Host port, combinational read
  input  soc_mem_pkg::mem_addr_t host_addr_i,
  input  soc_mem_pkg::mem_word_t host_wdata_i,
  input  logic                   host_we_i,
  output soc_mem_pkg::mem_word_t host_rdata_o,
  // RX engine, read only
  input  logic                   rx_req_i,
  input  soc_mem_pkg::mem_addr_t rx_addr_i,
  output logic                   rx_gnt_o,
  // TX engine, write only in practice
  input  logic                   tx_req_i,
  input  logic                   tx_we_i,
  input  soc_mem_pkg::mem_addr_t tx_addr_i,
  input  soc_mem_pkg::mem_word_t tx_wdata_i,
  output logic                   tx_gnt_o,
  // Engine read data, follows rx_addr_i
  output soc_mem_pkg::mem_word_t eng_rdata_o
);
  import soc_mem_pkg::*;

  localparam int IDX_W = $clog2(`SOC_SRAM_DEPTH);

  mem_word_t        mem [`SOC_SRAM_DEPTH];
  logic [IDX_W-1:0] host_idx;
  logic [IDX_W-1:0] rx_idx;
  logic [IDX_W-1:0] tx_idx;

  // Byte address to word index, wraps at the array size
  assign host_idx = host_addr_i[3 +: IDX_W];
  assign rx_idx   = rx_addr_i[3 +: IDX_W];
  assign tx_idx   = tx_addr_i[3 +: IDX_W];

  assign host_rdata_o = mem[host_idx];
  assign eng_rdata_o  = mem[rx_idx];

  // Fixed priority, a host write stalls both engines
  assign tx_gnt_o = tx_req_i && !host_we_i;
  assign rx_gnt_o = rx_req_i && !host_we_i && !tx_req_i;

  always_ff @(posedge clk) begin
    if (host_we_i) begin
      mem[host_idx] <= host_wdata_i;
    end else if (tx_gnt_o && tx_we_i) begin
      mem[tx_idx] <= tx_wdata_i;
    end
  end

  // At most one access owns the array per cycle
  a_one_owner: assert property (@(posedge clk) disable iff (!rstn)
    !(rx_gnt_o && tx_gnt_o) && !(host_we_i && (rx_gnt_o || tx_gnt_o)))
    else $error("SRAM grant overlap");

endmodule

//--- rtl/dma_rx_engine.sv
// DMA RX engine, reads three SRAM words per packet and offers the flat packet downstream
`timescale 1ns/10ps
`include "soc_dma_cfg.svh"

module dma_rx_engine (
  input  logic                    clk,
  input  logic                    rstn,
  // Job control
  input  logic                    start_i,
  input  soc_mem_pkg::mem_addr_t  src_addr_i,
  input  soc_mem_pkg::pkt_count_t len_i,
  output logic                    busy_o,
  output logic                    done_o,
  // SRAM word port
  output logic                    mem_req_o,
  input  logic                    mem_gnt_i,
  output soc_mem_pkg::mem_addr_t  mem_addr_o,
  input  soc_mem_pkg::mem_word_t  mem_rdata_i,
  // Packet stream out
  output soc_mem_pkg::pkt_flat_t  pkt_data_o,
  output logic                    pkt_valid_o,
  input  logic                    pkt_ready_i
);
  import soc_mem_pkg::*;

  localparam int                BEAT_W     = $clog2(`SOC_BEATS_PER_PKT);
  localparam logic [BEAT_W-1:0] LAST_BEAT  = BEAT_W'(`SOC_BEATS_PER_PKT - 1);
  localparam mem_addr_t         WORD_BYTES = mem_addr_t'(`SOC_WORD_W / 8);

  typedef enum logic [1:0] {RX_IDLE, RX_READ, RX_OFFER, RX_DONE} rx_state_e;

  rx_state_e         state_q;
  logic [BEAT_W-1:0] beat_q;
  pkt_count_t        pkts_left_q;
  mem_addr_t         addr_q;
  pkt_flat_t         pkt_q;

  assign busy_o      = (state_q == RX_READ) || (state_q == RX_OFFER);
  assign done_o      = (state_q == RX_DONE);
  assign mem_req_o   = (state_q == RX_READ);
  assign mem_addr_o  = addr_q;
  assign pkt_valid_o = (state_q == RX_OFFER);
  assign pkt_data_o  = pkt_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q     <= RX_IDLE;
      beat_q      <= '0;
      pkts_left_q <= '0;
      addr_q      <= '0;
    end else begin
      case (state_q)
        RX_IDLE: begin
          if (start_i) begin
            addr_q      <= src_addr_i;
            pkts_left_q <= len_i;
            beat_q      <= '0;
            // Empty job finishes at once
            state_q     <= (len_i == '0) ? RX_DONE : RX_READ;
          end
        end
        RX_READ: begin
          // Address advances per granted word, so packet k starts at SRC + 24k
          if (mem_gnt_i) begin
            addr_q <= addr_q + WORD_BYTES;
            if (beat_q == LAST_BEAT) begin
              beat_q  <= '0;
              state_q <= RX_OFFER;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        RX_OFFER: begin
          if (pkt_ready_i) begin
            pkts_left_q <= pkts_left_q - 1'b1;
            state_q     <= (pkts_left_q == 1) ? RX_DONE : RX_READ;
          end
        end
        // RX_DONE lasts one cycle
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Word j lands at bits 64j and up
  always_ff @(posedge clk) begin
    if ((state_q == RX_READ) && mem_gnt_i) begin
      pkt_q[beat_q*`SOC_WORD_W +: `SOC_WORD_W] <= mem_rdata_i;
    end
  end

  // Offered packet stays put until taken
  a_hold_pkt: assert property (@(posedge clk) disable iff (!rstn)
    pkt_valid_o && !pkt_ready_i |=> pkt_valid_o && $stable(pkt_data_o))
    else $error("RX packet changed while stalled");

endmodule

//--- rtl/dma_tx_engine.sv
// DMA TX engine, takes one flat packet and writes it to the SRAM as three words
`timescale 1ns/10ps
`include "soc_dma_cfg.svh"

module dma_tx_engine (
  input  logic                    clk,
  input  logic                    rstn,
  // Job control
  input  logic                    start_i,
  input  soc_mem_pkg::mem_addr_t  dst_addr_i,
  input  soc_mem_pkg::pkt_count_t len_i,
  output logic                    busy_o,
  output logic                    done_o,
  // Packet stream in
  input  soc_mem_pkg::pkt_flat_t  pkt_data_i,
  input  logic                    pkt_valid_i,
  output logic                    pkt_ready_o,
  // SRAM word port
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  input  logic                    mem_gnt_i,
  output soc_mem_pkg::mem_addr_t  mem_addr_o,
  output soc_mem_pkg::mem_word_t  mem_wdata_o
);
  import soc_mem_pkg::*;

  localparam int                BEAT_W     = $clog2(`SOC_BEATS_PER_PKT);
  localparam logic [BEAT_W-1:0] LAST_BEAT  = BEAT_W'(`SOC_BEATS_PER_PKT - 1);
  localparam mem_addr_t         WORD_BYTES = mem_addr_t'(`SOC_WORD_W / 8);

  typedef enum logic [1:0] {TX_IDLE, TX_CAPTURE, TX_WRITE, TX_DONE} tx_state_e;

  tx_state_e         state_q;
  logic [BEAT_W-1:0] beat_q;
  pkt_count_t        pkts_left_q;
  mem_addr_t         addr_q;
  pkt_flat_t         buf_q;

  assign busy_o      = (state_q == TX_CAPTURE) || (state_q == TX_WRITE);
  assign done_o      = (state_q == TX_DONE);
  assign pkt_ready_o = (state_q == TX_CAPTURE);
  // Every access of this engine is a full-word write
  assign mem_req_o   = (state_q == TX_WRITE);
  assign mem_we_o    = mem_req_o;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = buf_q[beat_q*`SOC_WORD_W +: `SOC_WORD_W];

  // --------------------------------------------------
  // Job FSM
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q     <= TX_IDLE;
      beat_q      <= '0;
      pkts_left_q <= '0;
      addr_q      <= '0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (start_i) begin
            addr_q      <= dst_addr_i;
            pkts_left_q <= len_i;
            beat_q      <= '0;
            state_q     <= (len_i == '0) ? TX_DONE : TX_CAPTURE;
          end
        end
        TX_CAPTURE: begin
          if (pkt_valid_i) state_q <= TX_WRITE;
        end
        TX_WRITE: begin
          // One word per grant, address and word select held otherwise
          if (mem_gnt_i) begin
            addr_q <= addr_q + WORD_BYTES;
            if (beat_q == LAST_BEAT) begin
              beat_q      <= '0;
              pkts_left_q <= pkts_left_q - 1'b1;
              state_q     <= (pkts_left_q == 1) ? TX_DONE : TX_CAPTURE;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        // TX_DONE gives the one-cycle done pulse
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // Packet buffer
  always_ff @(posedge clk) begin
    if ((state_q == TX_CAPTURE) && pkt_valid_i) begin
      buf_q <= pkt_data_i;
    end
  end

  a_we_needs_req: assert property (@(posedge clk) disable iff (!rstn)
    mem_we_o |-> mem_req_o)
    else $error("TX write enable without request");

endmodule

//--- rtl/cgra_loopback.sv
// Accelerator stand-in, unpacks each packet into a one-entry buffer and repacks it
`timescale 1ns/10ps
`include "soc_dma_cfg.svh"

module cgra_loopback (
  input  logic                   clk,
  input  logic                   rstn,
  // From the RX engine
  input  soc_mem_pkg::pkt_flat_t in_data_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  // To the TX engine
  output soc_mem_pkg::pkt_flat_t out_data_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i
);
  import cgra_pkt_pkg::*;

  localparam int PAD_W = `SOC_PKT_FLAT_W - `SOC_CGRA_PKT_W;

  cgra_pkt_t pkt_q;
  logic      full_q;

  // Accept only into an empty slot, nothing is dropped
  assign in_ready_o  = !full_q;
  assign out_valid_o = full_q;
  // Pad bits above the packet go out as zero
  assign out_data_o  = {{PAD_W{1'b0}}, pack_pkt(pkt_q)};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      full_q <= 1'b0;
    end else if (in_valid_i && !full_q) begin
      full_q <= 1'b1;
    end else if (out_ready_i && full_q) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && !full_q) begin
      pkt_q <= unpack_pkt(in_data_i[`SOC_CGRA_PKT_W-1:0]);
    end
  end

endmodule

//--- rtl/soc_dma_top.sv
// Streaming subsystem top with host port, SRAM, DMA registers, duplex DMA and loopback
`timescale 1ns/10ps

module soc_dma_top (
  input  logic                   clk,
  input  logic                   rstn,
  input  soc_mem_pkg::mem_addr_t host_addr_i,
  input  soc_mem_pkg::mem_word_t host_wdata_i,
  input  logic                   host_we_i,
  output soc_mem_pkg::mem_word_t host_rdata_o
);
  import soc_mem_pkg::*;

  // Host to SRAM
  logic       ram_we;
  mem_word_t  ram_rdata;
  // CSR to engines
  logic       start_rx, busy_rx, done_rx;
  logic       start_tx, busy_tx, done_tx;
  mem_addr_t  src_rx, dst_tx;
  pkt_count_t len_rx, len_tx;
  // Engine SRAM ports
  logic       rx_req, rx_gnt, tx_req, tx_we, tx_gnt;
  mem_addr_t  rx_addr, tx_addr;
  mem_word_t  tx_wdata, eng_rdata;
  // Packet streams
  pkt_flat_t  rx_pkt, tx_pkt;
  logic       rx_valid, rx_ready, tx_valid, tx_ready;

  dma_csr u_csr (
    .clk(clk), .rstn(rstn),
    .host_addr_i(host_addr_i), .host_wdata_i(host_wdata_i), .host_we_i(host_we_i),
    .host_rdata_o(host_rdata_o), .ram_we_o(ram_we), .ram_rdata_i(ram_rdata),
    .start_rx_o(start_rx), .src_rx_o(src_rx), .len_rx_o(len_rx),
    .busy_rx_i(busy_rx), .done_rx_i(done_rx),
    .start_tx_o(start_tx), .dst_tx_o(dst_tx), .len_tx_o(len_tx),
    .busy_tx_i(busy_tx), .done_tx_i(done_tx)
  );

  shared_sram u_sram (
    .clk(clk), .rstn(rstn),
    .host_addr_i(host_addr_i), .host_wdata_i(host_wdata_i), .host_we_i(ram_we),
    .host_rdata_o(ram_rdata),
    .rx_req_i(rx_req), .rx_addr_i(rx_addr), .rx_gnt_o(rx_gnt),
    .tx_req_i(tx_req), .tx_we_i(tx_we), .tx_addr_i(tx_addr), .tx_wdata_i(tx_wdata),
    .tx_gnt_o(tx_gnt), .eng_rdata_o(eng_rdata)
  );

  dma_rx_engine u_rx (
    .clk(clk), .rstn(rstn),
    .start_i(start_rx), .src_addr_i(src_rx), .len_i(len_rx),
    .busy_o(busy_rx), .done_o(done_rx),
    .mem_req_o(rx_req), .mem_gnt_i(rx_gnt), .mem_addr_o(rx_addr), .mem_rdata_i(eng_rdata),
    .pkt_data_o(rx_pkt), .pkt_valid_o(rx_valid), .pkt_ready_i(rx_ready)
  );

  cgra_loopback u_cgra (
    .clk(clk), .rstn(rstn),
    .in_data_i(rx_pkt), .in_valid_i(rx_valid), .in_ready_o(rx_ready),
    .out_data_o(tx_pkt), .out_valid_o(tx_valid), .out_ready_i(tx_ready)
  );

  dma_tx_engine u_tx (
    .clk(clk), .rstn(rstn),
    .start_i(start_tx), .dst_addr_i(dst_tx), .len_i(len_tx),
    .busy_o(busy_tx), .done_o(done_tx),
    .pkt_data_i(tx_pkt), .pkt_valid_i(tx_valid), .pkt_ready_o(tx_ready),
    .mem_req_o(tx_req), .mem_we_o(tx_we), .mem_gnt_i(tx_gnt),
    .mem_addr_o(tx_addr), .mem_wdata_o(tx_wdata)
  );

endmodule

//--- sim/tb_soc_dma.sv
// Testbench for the SRAM/DMA streaming subsystem, host-port stimulus with assertion checks
`timescale 1ns/10ps
`include "soc_dma_cfg.svh"

module tb_soc_dma;
  import soc_mem_pkg::*;
  import cgra_pkt_pkg::*;

  localparam time       CLK_PERIOD     = 100;
  localparam int        STATUS_TIMEOUT = 500;
  localparam int        HOLD_CYCLES    = 40;
  localparam mem_addr_t WORD_BYTES     = `SOC_WORD_W / 8;

  logic      clk;
  logic      rstn;
  mem_addr_t host_addr;
  mem_word_t host_wdata;
  logic      host_we;
  mem_word_t host_rdata;

  // Expected SRAM image, filled as the host writes source words
  mem_word_t model [`SOC_SRAM_DEPTH];
  integer    seed;

  soc_dma_top dut_i (
    .clk(clk), .rstn(rstn),
    .host_addr_i(host_addr), .host_wdata_i(host_wdata), .host_we_i(host_we),
    .host_rdata_o(host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic int word_index(input mem_addr_t addr);
    return int'((addr / WORD_BYTES) % `SOC_SRAM_DEPTH);
  endfunction

  function automatic mem_addr_t csr_addr(input mem_addr_t offset);
    return `SOC_MMIO_BASE + offset;
  endfunction

  function automatic mem_word_t random_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic compare_word(input string name, input mem_word_t expected,
                              input mem_word_t actual);
    assert (actual === expected) else begin
      $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first error");
    end
  endtask

  // Write lands at the rising edge inside the cycle
  task automatic host_write(input mem_addr_t addr, input mem_word_t data);
    @(negedge clk);
    host_addr  = addr;
    host_wdata = data;
    host_we    = 1'b1;
    @(negedge clk);
    host_we    = 1'b0;
  endtask

  // Read data is combinational, sampled a quarter cycle after the address
  task automatic host_read(input mem_addr_t addr, output mem_word_t data);
    @(negedge clk);
    host_addr = addr;
    host_we   = 1'b0;
    #(CLK_PERIOD / 4);
    data = host_rdata;
  endtask

  task automatic read_expect(input string name, input mem_addr_t addr,
                             input mem_word_t expected);
    mem_word_t data;
    host_read(addr, data);
    compare_word(name, expected, data);
  endtask

  // Poll STATUS until the masked bits match, bounded by STATUS_TIMEOUT reads
  task automatic wait_status(input logic [3:0] mask, input logic [3:0] value,
                             input string what);
    mem_word_t status;
    int        reads;
    reads = 0;
    host_read(csr_addr(`SOC_REG_STATUS), status);
    while ((status[3:0] & mask) != value) begin
      reads++;
      if (reads > STATUS_TIMEOUT) begin
        $display("Timed out waiting for %s, STATUS stuck at 0x%h", what, status[3:0]);
        $display("RESULT: FAIL");
        $fatal(1, "stopping on timeout");
      end
      host_read(csr_addr(`SOC_REG_STATUS), status);
    end
  endtask

  // Random source words, three per packet
  task automatic load_source(input mem_addr_t src, input int npkts);
    mem_word_t w;
    mem_addr_t a;
    for (int i = 0; i < npkts * `SOC_BEATS_PER_PKT; i++) begin
      a = src + i * WORD_BYTES;
      w = random_word();
      model[word_index(a)] = w;
      host_write(a, w);
    end
  endtask

  task automatic program_job(input mem_addr_t src, input mem_addr_t dst, input int npkts);
    host_write(csr_addr(`SOC_REG_SRC_RX), mem_word_t'(src));
    host_write(csr_addr(`SOC_REG_DST_TX), mem_word_t'(dst));
    host_write(csr_addr(`SOC_REG_LEN_RX), mem_word_t'(npkts));
    host_write(csr_addr(`SOC_REG_LEN_TX), mem_word_t'(npkts));
  endtask

  // Destination equals source except the 7 pad bits on top of word 2
  task automatic check_copy(input mem_addr_t src, input mem_addr_t dst, input int npkts);
    mem_word_t expected;
    mem_addr_t sa;
    mem_addr_t da;
    for (int i = 0; i < npkts * `SOC_BEATS_PER_PKT; i++) begin
      sa = src + i * WORD_BYTES;
      da = dst + i * WORD_BYTES;
      expected = model[word_index(sa)];
      if (i % `SOC_BEATS_PER_PKT == 2) expected[63:57] = 7'h0;
      read_expect($sformatf("sram[0x%h]", da), da, expected);
      // Source region untouched by the copy
      read_expect($sformatf("sram[0x%h]", sa), sa, model[word_index(sa)]);
    end
  endtask

  task automatic run_duplex(input mem_addr_t src, input mem_addr_t dst, input int npkts);
    load_source(src, npkts);
    program_job(src, dst, npkts);
    host_write(csr_addr(`SOC_REG_CONTROL), 64'h3);
    wait_status(4'hF, 4'hA, "done_rx and done_tx with both engines idle");
    check_copy(src, dst, npkts);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    mem_word_t w;
    mem_word_t rd;
    seed       = 48;
    rstn       = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_we    = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    compare_word("cgra_pkt_t width", 64'd185, 64'($bits(cgra_pkt_t)));

    // Register reset values
    read_expect("CONTROL", csr_addr(`SOC_REG_CONTROL), '0);
    read_expect("SRC_RX", csr_addr(`SOC_REG_SRC_RX), '0);
    read_expect("DST_TX", csr_addr(`SOC_REG_DST_TX), '0);
    read_expect("LEN_RX", csr_addr(`SOC_REG_LEN_RX), '0);
    read_expect("LEN_TX", csr_addr(`SOC_REG_LEN_TX), '0);
    read_expect("STATUS", csr_addr(`SOC_REG_STATUS), '0);

    // 32-bit register read-back
    w = random_word();
    w[63:32] = '0;
    host_write(csr_addr(`SOC_REG_SRC_RX), w);
    read_expect("SRC_RX", csr_addr(`SOC_REG_SRC_RX), w);
    w = random_word();
    w[63:32] = '0;
    host_write(csr_addr(`SOC_REG_DST_TX), w);
    read_expect("DST_TX", csr_addr(`SOC_REG_DST_TX), w);
    w = random_word();
    w[63:32] = '0;
    host_write(csr_addr(`SOC_REG_LEN_RX), w);
    read_expect("LEN_RX", csr_addr(`SOC_REG_LEN_RX), w);
    w = random_word();
    w[63:32] = '0;
    host_write(csr_addr(`SOC_REG_LEN_TX), w);
    read_expect("LEN_TX", csr_addr(`SOC_REG_LEN_TX), w);

    // SRAM through the host port
    load_source(32'h0000_0040, 1);
    load_source(32'h0000_1F00, 1);
    read_expect("sram[0x40]", 32'h0000_0040, model[word_index(32'h0000_0040)]);
    read_expect("sram[0x48]", 32'h0000_0048, model[word_index(32'h0000_0048)]);
    read_expect("sram[0x1f10]", 32'h0000_1F10, model[word_index(32'h0000_1F10)]);
    // Window write at offset 0x40 aliases word 8 but must not reach it
    host_write(csr_addr(32'h40), ~model[word_index(32'h0000_0040)]);
    read_expect("sram[0x40] after MMIO write", 32'h0000_0040,
                model[word_index(32'h0000_0040)]);

    // Single packet, then four packets at spread-out regions
    run_duplex(32'h0000_0100, 32'h0000_0300, 1);
    run_duplex(32'h0000_0800, 32'h0000_1400, 4);

    // Back-pressure, RX alone stalls once the loopback is full
    load_source(32'h0000_0A00, 3);
    program_job(32'h0000_0A00, 32'h0000_1800, 3);
    host_write(csr_addr(`SOC_REG_CONTROL), 64'h1);
    wait_status(4'h1, 4'h1, "busy_rx");
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      host_read(csr_addr(`SOC_REG_STATUS), rd);
      compare_word("STATUS[1:0] while stalled", 64'h1, rd & 64'h3);
    end
    host_write(csr_addr(`SOC_REG_CONTROL), 64'h2);
    wait_status(4'hF, 4'hA, "done bits after releasing back-pressure");
    check_copy(32'h0000_0A00, 32'h0000_1800, 3);

    // Each start clears only its own sticky done bit
    load_source(32'h0000_1A00, 1);
    program_job(32'h0000_1A00, 32'h0000_1C00, 1);
    host_write(csr_addr(`SOC_REG_CONTROL), 64'h1);
    host_read(csr_addr(`SOC_REG_STATUS), rd);
    compare_word("STATUS done bits after RX start", 64'h8, rd & 64'hA);
    host_write(csr_addr(`SOC_REG_CONTROL), 64'h2);
    host_read(csr_addr(`SOC_REG_STATUS), rd);
    compare_word("STATUS done_tx after TX start", 64'h0, rd & 64'h8);
    wait_status(4'hF, 4'hA, "done bits set again");
    check_copy(32'h0000_1A00, 32'h0000_1C00, 1);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- project.f
+incdir+rtl
rtl/soc_mem_pkg.sv
rtl/cgra_pkt_pkg.sv
rtl/dma_csr.sv
rtl/shared_sram.sv
rtl/dma_rx_engine.sv
rtl/dma_tx_engine.sv
rtl/cgra_loopback.sv
rtl/soc_dma_top.sv
sim/tb_soc_dma.sv
